// File: tb.f
hdl/rename_pkg.sv
hdl/free_reg_picker.sv
hdl/free_list.sv
hdl/map_table.sv
hdl/branch_checkpoint.sv
hdl/rename_stage.sv
hdl/rename_unit.sv
tests/rename_tb.sv

// File: Bender.yml
package:
  name: rename_unit

sources:
  - hdl/rename_pkg.sv
  - hdl/free_reg_picker.sv
  - hdl/free_list.sv
  - hdl/map_table.sv
  - hdl/branch_checkpoint.sv
  - hdl/rename_stage.sv
  - hdl/rename_unit.sv
  - target: test
    files:
      - tests/rename_tb.sv

// File: tests/rename_tb.sv
`timescale 1ns/1ps

module rename_tb import rename_pkg::*; ();

    localparam int timeout_cycles = 60;   // tests run about 21 cycles, rest is margin

    logic                              clock;
    logic                              reset;
    logic [rename_width-1:0]           rename_valid;
    arch_reg_idx_t [rename_width-1:0]  dest_arch;
    arch_reg_idx_t [rename_width-1:0]  src1_arch;
    arch_reg_idx_t [rename_width-1:0]  src2_arch;
    logic [rename_width-1:0]           complete_valid;
    phys_reg_idx_t [rename_width-1:0]  complete_tag;
    logic [retire_count_bits-1:0]      retire_count;
    phys_reg_idx_t [rename_width-1:0]  retire_tag;
    logic                              checkpoint_save;
    logic                              restore_flag;
    phys_reg_idx_t [rename_width-1:0]  new_tag, old_tag, src1_tag, src2_tag;
    logic [rename_width-1:0]           src1_ready, src2_ready;
    logic                              rename_stall;
    logic                              checkpoint_valid;

    // reference model of free list, complete list, map table and the checkpoint slot
    phys_vec_t  model_free, model_complete, snap_free;
    map_vec_t   model_map, snap_map;
    logic       snap_valid;

    // DUT response sampled in the last step
    phys_reg_idx_t [rename_width-1:0]  seen_new;
    logic [rename_width-1:0]           seen_rdy1, seen_rdy2;
    logic                              seen_stall;

    int unsigned seed = 61534;
    int          cycle_count = 0;

    rename_unit i_rename_unit (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;   // 4 ns period
    end

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("RESULT: FAIL");
            $fatal(1, "timeout, the tests did not finish within %0d cycles", timeout_cycles);
        end
    end

    task automatic check_tag(input phys_reg_idx_t got, input phys_reg_idx_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %0d, expected %0d", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "tag mismatch");
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "bit mismatch");
        end
    endtask

    task automatic check_vec(input phys_vec_t got, input phys_vec_t exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s is %b, expected %b", $time, what, got, exp);
            $display("RESULT: FAIL");
            $fatal(1, "vector mismatch");
        end
    endtask

    function automatic arch_reg_idx_t lcg_arch();
        seed = seed * 32'd1103515245 + 32'd12345;
        return arch_reg_idx_t'(seed >> 16);   // upper bits are the better ones
    endfunction

    task automatic clear_inputs();
        rename_valid    = '0;
        dest_arch       = '0;
        src1_arch       = '0;
        src2_arch       = '0;
        complete_valid  = '0;
        complete_tag    = '0;
        retire_count    = '0;
        retire_tag      = '0;
        checkpoint_save = 1'b0;
        restore_flag    = 1'b0;
    endtask

    task automatic reset_model();
        for (int p = 0; p < phys_reg_count; p++) begin
            model_free[p]     = (p >= arch_reg_count);   // upper half starts free
            model_complete[p] = (p < arch_reg_count);
        end
        for (int a = 0; a < arch_reg_count; a++) begin
            model_map[a] = phys_reg_idx_t'(a);   // identity
        end
        snap_free  = '0;
        snap_map   = '0;
        snap_valid = 1'b0;
    endtask

    task automatic set_lane(input int lane, input logic valid, input arch_reg_idx_t dest,
                            input arch_reg_idx_t src1, input arch_reg_idx_t src2);
        rename_valid[lane] = valid;
        dest_arch[lane]    = dest;
        src1_arch[lane]    = src1;
        src2_arch[lane]    = src2;
    endtask

    // one cycle: check the combinational response, then apply the edge to the model
    task automatic step();
        phys_reg_idx_t [rename_width-1:0]  grant, exp_new;
        phys_reg_idx_t                     exp_old, exp_s1, exp_s2;
        logic                              rdy1, rdy2, exp_stall;
        int                                nfree, nreq;
        phys_vec_t                         alloc, next_free;
        map_vec_t                          next_map;
        grant   = '0;
        exp_new = '0;
        nfree   = 0;
        nreq    = 0;
        alloc   = '0;
        for (int p = 0; p < phys_reg_count; p++) begin
            if (model_free[p] && nfree < rename_width) begin
                grant[nfree] = phys_reg_idx_t'(p);   // lowest free first
                nfree++;
            end
        end
        for (int i = 0; i < rename_width; i++) begin
            if (rename_valid[i]) begin
                exp_new[i] = grant[nreq];   // idle lanes skip a grant
                nreq++;
            end
        end
        exp_stall = restore_flag || (nreq > nfree);
        #1;
        seen_new   = new_tag;
        seen_rdy1  = src1_ready;
        seen_rdy2  = src2_ready;
        seen_stall = rename_stall;
        check_bit(rename_stall, exp_stall, "rename_stall");
        check_bit(checkpoint_valid, snap_valid, "checkpoint_valid");
        for (int i = 0; i < rename_width; i++) begin
            exp_old = model_map[dest_arch[i]];
            exp_s1  = model_map[src1_arch[i]];
            exp_s2  = model_map[src2_arch[i]];
            rdy1    = model_complete[exp_s1];
            rdy2    = model_complete[exp_s2];
            for (int j = 0; j < i; j++) begin   // older lane in the group is the producer
                if (rename_valid[j] && dest_arch[j] == dest_arch[i]) exp_old = exp_new[j];
                if (rename_valid[j] && dest_arch[j] == src1_arch[i]) begin
                    exp_s1 = exp_new[j];
                    rdy1   = 1'b0;
                end
                if (rename_valid[j] && dest_arch[j] == src2_arch[i]) begin
                    exp_s2 = exp_new[j];
                    rdy2   = 1'b0;
                end
            end
            if (!exp_stall && rename_valid[i]) begin
                check_tag(new_tag[i], exp_new[i], $sformatf("lane %0d new_tag", i));
                check_tag(old_tag[i], exp_old, $sformatf("lane %0d old_tag", i));
            end
            if (!exp_stall) begin
                check_tag(src1_tag[i], exp_s1, $sformatf("lane %0d src1_tag", i));
                check_bit(src1_ready[i], rdy1, $sformatf("lane %0d src1_ready", i));
                check_tag(src2_tag[i], exp_s2, $sformatf("lane %0d src2_tag", i));
                check_bit(src2_ready[i], rdy2, $sformatf("lane %0d src2_ready", i));
            end
        end
        @(posedge clock);
        next_map = model_map;
        if (restore_flag) begin
            next_map = snap_map;
        end else if (!exp_stall) begin
            for (int i = 0; i < rename_width; i++) begin
                if (rename_valid[i]) begin
                    next_map[dest_arch[i]] = exp_new[i];   // younger lane written last
                    alloc[exp_new[i]]      = 1'b1;
                end
            end
        end
        next_free = model_free & ~alloc;
        for (int i = 0; i < retire_count; i++) begin
            next_free[retire_tag[i]] = 1'b1;
        end
        if (restore_flag) next_free = next_free | snap_free;
        for (int i = 0; i < rename_width; i++) begin
            if (complete_valid[i]) model_complete[complete_tag[i]] = 1'b1;
        end
        model_complete = model_complete & ~alloc;   // allocation beats completion
        if (restore_flag) begin
            snap_valid = 1'b0;
        end else if (checkpoint_save) begin
            snap_free  = model_free;   // state before this edge
            snap_map   = model_map;
            snap_valid = 1'b1;
        end
        model_map  = next_map;
        model_free = next_free;
        @(negedge clock);
        clear_inputs();
    endtask

    // lookups of every arch register through the source ports, no renames
    task automatic lookup_all();
        for (int base = 0; base < arch_reg_count; base += 4) begin
            set_lane(0, 1'b0, 0, arch_reg_idx_t'(base), arch_reg_idx_t'(base + 1));
            set_lane(1, 1'b0, 0, arch_reg_idx_t'(base + 2), arch_reg_idx_t'(base + 3));
            step();
        end
    endtask

    task automatic test_reset_state();
        lookup_all();
        check_bit(&{seen_rdy1, seen_rdy2}, 1'b1, "sources ready after reset");
        set_lane(0, 1'b1, 1, 0, 0);
        set_lane(1, 1'b1, 2, 1, 1);
        step();
        check_tag(seen_new[0], 8, "first rename lane 0");
        check_tag(seen_new[1], 9, "first rename lane 1");
    endtask

    task automatic test_alloc_forward();
        set_lane(0, 1'b1, 3, 1, 2);
        set_lane(1, 1'b1, 3, 3, 0);   // same dest, src1 from lane 0
        step();
        check_bit(seen_rdy1[1], 1'b0, "forwarded source");
        set_lane(1, 1'b1, 4, 3, 4);   // lane 0 idle
        step();
        check_tag(seen_new[1], 12, "lane 1 alone takes the lowest free");
    endtask

    task automatic test_completion();
        complete_valid  = 2'b11;
        complete_tag[0] = 8;
        complete_tag[1] = 13;   // allocated in this same cycle
        set_lane(0, 1'b1, 5, 1, 1);
        step();
        set_lane(0, 1'b0, 0, 1, 5);   // arch 1 in 8, arch 5 in 13
        step();
        check_bit(seen_rdy1[0], 1'b1, "completed tag");
        check_bit(seen_rdy2[0], 1'b0, "tag completed while allocated");
    endtask

    task automatic test_retire_stall();
        set_lane(0, 1'b1, 6, 0, 0);
        set_lane(1, 1'b1, 7, 6, 0);   // takes 14 and 15, list is empty
        step();
        for (int n = 0; n < 2; n++) begin
            set_lane(0, 1'b1, 0, 0, 0);   // requester holds
            if (n == 1) begin
                retire_count  = 2;
                retire_tag[0] = 1;   // old tags of arch 1 and 2
                retire_tag[1] = 2;
            end
            step();
            check_bit(seen_stall, 1'b1, "stall with no free register");
        end
        set_lane(0, 1'b1, 0, 0, 0);
        step();
        check_tag(seen_new[0], 1, "lowest retired register");
    endtask

    task automatic test_checkpoint();
        phys_vec_t exp_free;
        retire_count  = 2;
        retire_tag[0] = 3;    // old tags left by the arch 3 pair
        retire_tag[1] = 10;
        step();
        checkpoint_save = 1'b1;   // free list is {2, 3, 10} here
        step();
        check_bit(checkpoint_valid, 1'b1, "checkpoint_valid after save");
        set_lane(0, 1'b1, lcg_arch(), lcg_arch(), lcg_arch());
        set_lane(1, 1'b1, lcg_arch(), lcg_arch(), lcg_arch());
        step();
        set_lane(0, 1'b1, lcg_arch(), lcg_arch(), lcg_arch());
        retire_count  = 2;
        retire_tag[0] = 4;    // old tags of arch 4 and 5, freed after the save
        retire_tag[1] = 5;
        step();
        restore_flag = 1'b1;   // two registers free, so only the recovery stalls
        set_lane(0, 1'b1, lcg_arch(), lcg_arch(), lcg_arch());
        step();
        check_bit(seen_stall, 1'b1, "rename in the restore cycle");
        check_bit(checkpoint_valid, 1'b0, "checkpoint_valid after restore");
        exp_free     = '0;
        exp_free[2]  = 1'b1;   // saved set
        exp_free[3]  = 1'b1;
        exp_free[10] = 1'b1;
        exp_free[4]  = 1'b1;   // retired since
        exp_free[5]  = 1'b1;
        check_vec(i_rename_unit.free_vec, exp_free, "free list after restore");
        lookup_all();   // mappings back to the saved ones
    endtask

    initial begin
        clear_inputs();
        reset = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        reset_model();
        test_reset_state();
        test_alloc_forward();
        test_completion();
        test_retire_stall();
        test_checkpoint();
        $display("RESULT: PASS");
        $finish;
    end

endmodule

// File: hdl/rename_unit.sv
`timescale 1ns/1ps

module rename_unit import rename_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [rename_width-1:0]           rename_valid,
    input  arch_reg_idx_t [rename_width-1:0]  dest_arch,
    input  arch_reg_idx_t [rename_width-1:0]  src1_arch,
    input  arch_reg_idx_t [rename_width-1:0]  src2_arch,
    input  logic [rename_width-1:0]           complete_valid,
    input  phys_reg_idx_t [rename_width-1:0]  complete_tag,
    input  logic [retire_count_bits-1:0]      retire_count,
    input  phys_reg_idx_t [rename_width-1:0]  retire_tag,
    input  logic                              checkpoint_save,
    input  logic                              restore_flag,
    output phys_reg_idx_t [rename_width-1:0]  new_tag,
    output phys_reg_idx_t [rename_width-1:0]  old_tag,
    output phys_reg_idx_t [rename_width-1:0]  src1_tag,
    output logic [rename_width-1:0]           src1_ready,
    output phys_reg_idx_t [rename_width-1:0]  src2_tag,
    output logic [rename_width-1:0]           src2_ready,
    output logic                              rename_stall,
    output logic                              checkpoint_valid
);

    phys_vec_t                         free_vec, complete_vec, alloc_vec, free_snapshot;
    phys_reg_idx_t [rename_width-1:0]  grant_tag, map_phys;
    logic [retire_count_bits-1:0]      grant_count;
    logic [rename_width-1:0]           map_we;
    arch_reg_idx_t [rename_width-1:0]  map_arch;
    map_vec_t                          map_state, map_snapshot;

    free_reg_picker i_free_reg_picker (.free_vec, .grant_tag, .grant_count);

    free_list i_free_list (
        .clock, .reset, .alloc_vec, .retire_count, .retire_tag, .complete_valid, .complete_tag,
        .restore_flag, .free_restore(free_snapshot), .free_vec, .complete_vec
    );

    map_table i_map_table (
        .clock, .reset, .map_we, .map_arch, .map_phys, .restore_flag,
        .map_restore(map_snapshot), .map_state
    );

    rename_stage i_rename_stage (
        .rename_valid, .dest_arch, .src1_arch, .src2_arch, .grant_tag, .grant_count,
        .map_state, .complete_vec, .restore_flag, .alloc_vec, .map_we, .map_arch, .map_phys,
        .new_tag, .old_tag, .src1_tag, .src1_ready, .src2_tag, .src2_ready, .rename_stall
    );

    // both slots save and restore on the same strobes, so one valid flag serves
    branch_checkpoint #(.payload_t(phys_vec_t)) i_free_checkpoint (
        .clock, .reset, .save(checkpoint_save), .restore(restore_flag),
        .data_in(free_vec), .data_out(free_snapshot), .valid(checkpoint_valid)
    );

    branch_checkpoint #(.payload_t(map_vec_t)) i_map_checkpoint (
        .clock, .reset, .save(checkpoint_save), .restore(restore_flag),
        .data_in(map_state), .data_out(map_snapshot), .valid()
    );

endmodule

// File: hdl/rename_stage.sv
`timescale 1ns/1ps

module rename_stage import rename_pkg::*; (
    input  logic [rename_width-1:0]           rename_valid,
    input  arch_reg_idx_t [rename_width-1:0]  dest_arch,
    input  arch_reg_idx_t [rename_width-1:0]  src1_arch,
    input  arch_reg_idx_t [rename_width-1:0]  src2_arch,
    input  phys_reg_idx_t [rename_width-1:0]  grant_tag,     // from the picker, lowest first
    input  logic [retire_count_bits-1:0]      grant_count,
    input  map_vec_t                          map_state,
    input  phys_vec_t                         complete_vec,
    input  logic                              restore_flag,
    output phys_vec_t                         alloc_vec,
    output logic [rename_width-1:0]           map_we,
    output arch_reg_idx_t [rename_width-1:0]  map_arch,
    output phys_reg_idx_t [rename_width-1:0]  map_phys,
    output phys_reg_idx_t [rename_width-1:0]  new_tag,
    output phys_reg_idx_t [rename_width-1:0]  old_tag,
    output phys_reg_idx_t [rename_width-1:0]  src1_tag,
    output logic [rename_width-1:0]           src1_ready,
    output phys_reg_idx_t [rename_width-1:0]  src2_tag,
    output logic [rename_width-1:0]           src2_ready,
    output logic                              rename_stall
);

    logic [retire_count_bits-1:0] req_count;   // valid lanes this cycle

    // hand out grants to valid lanes in order, an idle lane takes no slot
    always_comb begin
        logic [retire_count_bits-1:0] slot;
        slot = '0;
        for (int i = 0; i < rename_width; i++) begin
            new_tag[i] = grant_tag[slot];
            if (rename_valid[i]) slot = slot + 1'b1;
        end
        req_count = slot;
    end

    assign rename_stall = restore_flag || (req_count > grant_count);   // shortage or recovery

    // table lookups, then forwarding from older lanes of the same group
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            old_tag[i]    = map_state[dest_arch[i]];
            src1_tag[i]   = map_state[src1_arch[i]];
            src2_tag[i]   = map_state[src2_arch[i]];
            src1_ready[i] = complete_vec[src1_tag[i]];
            src2_ready[i] = complete_vec[src2_tag[i]];
            for (int j = 0; j < i; j++) begin   // later j is younger, so it overrides
                if (rename_valid[j] && (dest_arch[j] == dest_arch[i])) old_tag[i] = new_tag[j];
                if (rename_valid[j] && (dest_arch[j] == src1_arch[i])) begin
                    src1_tag[i]   = new_tag[j];
                    src1_ready[i] = 1'b0;   // producer is in flight
                end
                if (rename_valid[j] && (dest_arch[j] == src2_arch[i])) begin
                    src2_tag[i]   = new_tag[j];
                    src2_ready[i] = 1'b0;
                end
            end
        end
    end

    // state writes, all gated by the stall
    always_comb begin
        alloc_vec = '0;
        for (int i = 0; i < rename_width; i++) begin
            map_we[i] = rename_valid[i] && !rename_stall;
            if (map_we[i]) alloc_vec[new_tag[i]] = 1'b1;
        end
    end

    assign map_arch = dest_arch;
    assign map_phys = new_tag;

endmodule

// File: hdl/branch_checkpoint.sv
`timescale 1ns/1ps

module branch_checkpoint #(
    parameter type payload_t = logic
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     save,       // take a snapshot at the branch
    input  logic     restore,    // mispredict, snapshot is consumed
    input  payload_t data_in,
    output payload_t data_out,
    output logic     valid       // slot holds a live snapshot
);

    payload_t snapshot;

    // snapshot storage
    always_ff @(posedge clock) begin
        if (save && !restore) begin
            snapshot <= data_in;
        end
    end

    assign data_out = snapshot;

    // slot state, restore beats save in the same cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (restore) begin
            valid <= 1'b0;
        end else if (save) begin
            valid <= 1'b1;
        end
    end

    // recovery without a prior save would load stale state
    restore_needs_snapshot: assert property (
        @(posedge clock) disable iff (reset)
        restore |-> valid
    ) else $error("restore with no valid checkpoint");

endmodule

// File: hdl/map_table.sv
`timescale 1ns/1ps

module map_table import rename_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  logic [rename_width-1:0]           map_we,        // per lane write strobe
    input  arch_reg_idx_t [rename_width-1:0]  map_arch,      // destination arch register
    input  phys_reg_idx_t [rename_width-1:0]  map_phys,      // new physical register
    input  logic                              restore_flag,
    input  map_vec_t                          map_restore,   // table at the checkpoint
    output map_vec_t                          map_state
);

    map_vec_t next_map;

    always_comb begin
        next_map = map_state;
        if (restore_flag) begin
            next_map = map_restore;   // whole table comes back, writes are dropped
        end else begin
            // lanes in program order, so the younger lane wins on a shared dest
            for (int i = 0; i < rename_width; i++) begin
                if (map_we[i]) begin
                    next_map[map_arch[i]] = map_phys[i];
                end
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            // identity map, arch i lives in phys i
            for (int i = 0; i < arch_reg_count; i++) begin
                map_state[i] <= phys_reg_idx_t'(i);
            end
        end else begin
            map_state <= next_map;
        end
    end

endmodule

// File: hdl/free_list.sv
`timescale 1ns/1ps

module free_list import rename_pkg::*; (
    input  logic                              clock,
    input  logic                              reset,
    input  phys_vec_t                         alloc_vec,       // registers taken by dispatch this cycle
    input  logic [retire_count_bits-1:0]      retire_count,    // first retire_count tags are valid
    input  phys_reg_idx_t [rename_width-1:0]  retire_tag,      // old tags leaving the machine
    input  logic [rename_width-1:0]           complete_valid,
    input  phys_reg_idx_t [rename_width-1:0]  complete_tag,    // result bus tags
    input  logic                              restore_flag,    // mispredict recovery
    input  phys_vec_t                         free_restore,    // free list at the checkpoint
    output phys_vec_t                         free_vec,
    output phys_vec_t                         complete_vec
);

    phys_vec_t next_free;
    phys_vec_t next_complete;

    // free list update
    // allocations leave first, then retired old tags come back
    always_comb begin
        next_free = free_vec & ~alloc_vec;
        for (int i = 0; i < rename_width; i++) begin
            if (i < retire_count) begin
                next_free[retire_tag[i]] = 1'b1;
            end
        end
        // registers freed since the checkpoint stay free on recovery
        if (restore_flag) begin
            next_free = next_free | free_restore;
        end
    end

    // complete list update
    always_comb begin
        next_complete = complete_vec;
        for (int i = 0; i < rename_width; i++) begin
            if (complete_valid[i]) begin
                next_complete[complete_tag[i]] = 1'b1;
            end
        end
        next_complete = next_complete & ~alloc_vec;   // a fresh destination has no value yet
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_vec     <= free_reset_vec;
            complete_vec <= complete_reset_vec;
        end else begin
            free_vec     <= next_free;
            complete_vec <= next_complete;
        end
    end

    // a retiring old tag is still owned by the machine until this edge
    for (genvar i = 0; i < rename_width; i++) begin : g_retire_check
        retire_not_free: assert property (
            @(posedge clock) disable iff (reset)
            (i < retire_count) |-> !free_vec[retire_tag[i]]
        ) else $error("retire of tag %0d that is already free", retire_tag[i]);
    end

    // dispatch may only take what the picker saw as free
    alloc_from_free: assert property (
        @(posedge clock) disable iff (reset)
        (alloc_vec & ~free_vec) == '0
    ) else $error("allocation of busy registers %b", alloc_vec & ~free_vec);

endmodule

// File: hdl/free_reg_picker.sv
`timescale 1ns/1ps

module free_reg_picker import rename_pkg::*; (
    input  phys_vec_t                         free_vec,     // 1 = register is free
    output phys_reg_idx_t [rename_width-1:0]  grant_tag,    // lowest free indices, slot 0 first
    output logic [retire_count_bits-1:0]      grant_count   // number of real grants
);

    // priority scan from index 0 upward
    // each hit fills the next grant slot until all slots are taken
    always_comb begin
        logic [retire_count_bits-1:0] count;
        count     = '0;
        grant_tag = '0;   // unused slots read as 0, grant_count marks them invalid
        for (int i = 0; i < phys_reg_count; i++) begin
            if (free_vec[i] && (count < rename_width)) begin
                grant_tag[count] = phys_reg_idx_t'(i);   // one-hot hit encoded to an index
                count            = count + 1'b1;
            end
        end
        grant_count = count;
    end

    // two real grants must never hand out the same register
    always_comb begin
        for (int i = 0; i < rename_width; i++) begin
            for (int j = 0; j < i; j++) begin
                if (i < grant_count) begin
                    assert final (grant_tag[i] != grant_tag[j])
                        else $error("grants %0d and %0d share tag %0d", j, i, grant_tag[i]);
                end
            end
        end
    end

endmodule

// File: hdl/rename_pkg.sv
package rename_pkg;

    // machine shape
    localparam int rename_width      = 2;   // instructions renamed per cycle
    localparam int arch_reg_count    = 8;
    localparam int phys_reg_count    = 16;
    localparam int phys_idx_bits     = 4;   // log2 of phys_reg_count
    localparam int arch_idx_bits     = 3;   // log2 of arch_reg_count
    localparam int retire_count_bits = 2;   // holds 0 .. rename_width

    // register indices
    typedef logic [phys_idx_bits-1:0] phys_reg_idx_t;
    typedef logic [arch_idx_bits-1:0] arch_reg_idx_t;

    // one bit per physical register, used for free, complete and grant vectors
    typedef logic [phys_reg_count-1:0] phys_vec_t;

    // whole map table, entry i is the physical register behind arch register i
    typedef phys_reg_idx_t [arch_reg_count-1:0] map_vec_t;

    // after reset the low physical registers back the identity map
    // so they hold a value already and are not free
    localparam phys_vec_t complete_reset_vec = phys_vec_t'((1 << arch_reg_count) - 1);
    localparam phys_vec_t free_reset_vec     = ~complete_reset_vec;   // upper half free

endpackage
